/* common/console_params.svh */
`ifndef CONSOLE_PARAMS_SVH
`define CONSOLE_PARAMS_SVH

// uart bit period in system clocks
`define CLKS_PER_BIT 16

// wishbone word address width
`define WB_ADDR_W 4

// register word offsets
`define REG_DATA   0
`define REG_CMD    1
`define REG_STATUS 2

`endif

/* common/print_types_pkg.sv */
package print_types_pkg;

    typedef logic [7:0]  char_t;  // one character on the tx line
    typedef logic [31:0] word_t;  // value handed to the print unit

    // how the word is rendered
    typedef enum logic {
        PRINT_BYTE_MODE = 1'b0,   // low byte, raw
        PRINT_WORD_MODE = 1'b1    // eight hex digits, msb first
    } print_mode_t;

    typedef enum logic [1:0] {
        PRINT_IDLE = 2'd0,
        PRINT_LOAD = 2'd1,
        PRINT_SEND = 2'd2,
        PRINT_WAIT = 2'd3
    } print_state_t;

    // 8n1 frame sequencer
    typedef enum logic [1:0] {
        UART_IDLE  = 2'd0,
        UART_START = 2'd1,
        UART_DATA  = 2'd2,
        UART_STOP  = 2'd3
    } uart_state_t;

endpackage

/* common/wb_types_pkg.sv */
`include "console_params.svh"

package wb_types_pkg;

    typedef logic [`WB_ADDR_W-1:0] wb_addr_t;  // word address
    typedef logic [31:0]           wb_data_t;
    typedef logic [3:0]            wb_sel_t;   // one bit per byte lane

    // decoded register target
    typedef enum logic [1:0] {
        REG_SEL_DATA   = 2'd0,
        REG_SEL_CMD    = 2'd1,
        REG_SEL_STATUS = 2'd2,
        REG_SEL_NONE   = 2'd3   // unmapped, acked but inert
    } reg_sel_t;

endpackage

/* console/uart_tx.sv */
`timescale 1ns/1ps
`include "console_params.svh"

module uart_tx
    import print_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  char_vld,
    input  char_t char_data,
    output logic  char_rdy,
    output logic  tx
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);

    uart_state_t      state;
    logic [CNT_W-1:0] clk_cnt;   // position inside the current bit
    logic [2:0]       bit_idx;   // data bit being sent
    char_t            shreg;     // lsb goes out first
    logic             bit_end;
    logic             line_bit;  // level for the current state

    assign char_rdy = (state == UART_IDLE);
    assign bit_end  = (clk_cnt == CNT_W'(`CLKS_PER_BIT - 1));

    always_comb begin
        case (state)
            UART_START: line_bit = 1'b0;
            UART_DATA:  line_bit = shreg[0];
            default:    line_bit = 1'b1;  // idle and stop are both mark
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= UART_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else begin
            tx      <= line_bit;  // registered, one cycle behind state
            clk_cnt <= (state == UART_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                UART_IDLE:  if (char_vld) state <= UART_START;
                UART_START: begin
                    if (bit_end) begin
                        bit_idx <= '0;
                        state   <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= UART_STOP;
                    end
                end
                UART_STOP:  if (bit_end) state <= UART_IDLE;
                default:    state <= UART_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (char_vld && char_rdy) shreg <= char_data;
        else if (state == UART_DATA && bit_end) shreg <= shreg >> 1;
    end

endmodule

/* console/print_unit.sv */
`timescale 1ns/1ps

module print_unit
    import print_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  print_mode_t mode,
    input  word_t       data,
    output logic        busy,
    output logic        char_vld,
    output char_t       char_data,
    input  logic        char_rdy
);

    print_state_t state;
    word_t        word;       // working copy, shifted one nibble per character
    logic [3:0]   count;      // characters still to hand off
    logic         done;       // one cycle after the last hand-off

    // nibble to upper case ascii hex
    function automatic char_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return char_t'(8'h30 + {4'h0, nib});
        end
        return char_t'(8'h37 + {4'h0, nib});  // 10 maps to "A"
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= PRINT_IDLE;
            count    <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
            char_vld <= 1'b0;
        end else begin
            done <= 1'b0;
            if (done) begin
                busy <= 1'b0;
            end
            case (state)
                PRINT_IDLE: begin
                    if (start) begin
                        busy  <= 1'b1;
                        state <= PRINT_LOAD;
                    end
                end
                PRINT_LOAD: begin
                    count <= (mode == PRINT_WORD_MODE) ? 4'd8 : 4'd1;
                    state <= PRINT_SEND;
                end
                PRINT_SEND: begin
                    char_vld <= 1'b1;  // char_data settles on the same edge
                    state    <= PRINT_WAIT;
                end
                PRINT_WAIT: begin
                    if (char_vld && char_rdy) begin
                        char_vld <= 1'b0;
                        count    <= count - 4'd1;
                        if (count == 4'd1) begin
                            done  <= 1'b1;
                            state <= PRINT_IDLE;
                        end else begin
                            state <= PRINT_SEND;
                        end
                    end
                end
                default: state <= PRINT_IDLE;
            endcase
        end
    end

    // datapath, follows the state machine above
    always_ff @(posedge clk) begin
        if (state == PRINT_LOAD) begin
            word <= data;  // snapshot, later bus writes do not matter
        end else if (state == PRINT_WAIT && char_vld && char_rdy) begin
            word <= word << 4;
        end

        if (state == PRINT_SEND) begin
            if (mode == PRINT_BYTE_MODE) begin
                char_data <= word[7:0];
            end else begin
                char_data <= hex_char(word[31:28]);  // top nibble first
            end
        end
    end

endmodule

/* source/wb_console_regs.sv */
`timescale 1ns/1ps
`include "console_params.svh"

module wb_console_regs
    import print_types_pkg::*, wb_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  wb_addr_t    adr,
    input  wb_data_t    dat_w,
    input  wb_sel_t     sel,
    output wb_data_t    dat_r,
    output logic        ack,
    output logic        start,
    output print_mode_t mode,
    output word_t       data,
    input  logic        busy
);

    reg_sel_t reg_sel;
    word_t    data_reg;  // bus visible data register
    wb_data_t rd_val;
    logic     req;       // new access pending and not yet acked
    logic     hold;      // cmd write must wait for the printer
    logic     take;      // access completes on this edge

    always_comb begin
        case (adr)
            wb_addr_t'(`REG_DATA):   reg_sel = REG_SEL_DATA;
            wb_addr_t'(`REG_CMD):    reg_sel = REG_SEL_CMD;
            wb_addr_t'(`REG_STATUS): reg_sel = REG_SEL_STATUS;
            default:                 reg_sel = REG_SEL_NONE;
        endcase
    end

    always_comb begin
        case (reg_sel)
            REG_SEL_DATA:   rd_val = data_reg;
            REG_SEL_CMD:    rd_val = {31'b0, mode};
            REG_SEL_STATUS: rd_val = {31'b0, busy};
            default:        rd_val = '0;
        endcase
    end

    assign req  = cyc && stb && !ack;
    assign hold = we && (reg_sel == REG_SEL_CMD) && busy;
    assign take = req && !hold;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack   <= 1'b0;
            start <= 1'b0;
            mode  <= PRINT_BYTE_MODE;
            dat_r <= '0;
        end else begin
            ack   <= take;
            start <= take && we && (reg_sel == REG_SEL_CMD);
            dat_r <= (take && !we) ? rd_val : '0;
            if (take && we && reg_sel == REG_SEL_CMD) begin
                mode <= print_mode_t'(dat_w[0]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && we && reg_sel == REG_SEL_DATA) begin
            for (int i = 0; i < 4; i++) begin
                if (sel[i]) data_reg[8*i +: 8] <= dat_w[8*i +: 8];
            end
        end
        // frozen copy for the printer that only moves on an accepted cmd
        if (take && we && reg_sel == REG_SEL_CMD) data <= data_reg;
    end

endmodule

/* source/console_top.sv */
`timescale 1ns/1ps

module console_top
    import print_types_pkg::*, wb_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cyc,
    input  logic     stb,
    input  logic     we,
    input  wb_addr_t adr,
    input  wb_data_t dat_w,
    input  wb_sel_t  sel,
    output wb_data_t dat_r,
    output logic     ack,
    output logic     tx
);

    logic        start;
    print_mode_t mode;
    word_t       data;
    logic        busy;
    logic        char_vld;
    char_t       char_data;
    logic        char_rdy;

    // bus side, command and data registers
    wb_console_regs u_regs (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .dat_r (dat_r),
        .ack   (ack),
        .start (start),
        .mode  (mode),
        .data  (data),
        .busy  (busy)
    );

    print_unit u_print (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .mode      (mode),
        .data      (data),
        .busy      (busy),
        .char_vld  (char_vld),
        .char_data (char_data),
        .char_rdy  (char_rdy)
    );

    uart_tx u_uart (
        .clk       (clk),
        .rst       (rst),
        .char_vld  (char_vld),
        .char_data (char_data),
        .char_rdy  (char_rdy),
        .tx        (tx)
    );

endmodule

/* sim/console_checker.sv */
`timescale 1ns/1ps

module console_checker
    import print_types_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  cyc,
    input logic  stb,
    input logic  ack,
    input logic  start,
    input logic  busy,
    input logic  char_vld,
    input logic  char_rdy,
    input char_t char_data,
    input logic  tx
);

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb))
        else $error("ack raised outside a bus cycle");

    ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack held for more than one cycle");

    // start always lands on an idle printer
    busy_follows: assert property (@(posedge clk) disable iff (rst) start |=> busy)
        else $error("busy did not rise after start");

    char_hold: assert property (@(posedge clk) disable iff (rst)
        (char_vld && !char_rdy) |=> (char_vld && $stable(char_data)))
        else $error("character changed before the transmitter took it");

    // char_rdy is the uart idle flag
    idle_mark: assert property (@(posedge clk) disable iff (rst) char_rdy |-> tx)
        else $error("tx low while the transmitter is idle");

endmodule

bind console_top console_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .cyc       (cyc),
    .stb       (stb),
    .ack       (ack),
    .start     (start),
    .busy      (busy),
    .char_vld  (char_vld),
    .char_rdy  (char_rdy),
    .char_data (char_data),
    .tx        (tx)
);

/* sim/console_tb.sv */
`timescale 1ns/1ps
`include "console_params.svh"

module console_tb
    import print_types_pkg::*, wb_types_pkg::*;
();

    localparam int FRAME_CYC = 10 * `CLKS_PER_BIT;
    localparam int LIMIT     = 40 * 8 * FRAME_CYC + 2000;  // about 13 word prints run

    logic     clk;
    logic     rst;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
    wb_sel_t  sel;
    wb_data_t dat_r;
    logic     ack;
    logic     tx;

    char_t       rx_q[$];     // characters decoded from tx
    int          errors;
    int          tests_ok;
    int          tests_bad;
    int          cycles;
    logic [31:0] rng;

    console_top UUT (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .dat_r (dat_r),
        .ack   (ack),
        .tx    (tx)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("test failed");
            $finish;
        end
    end

    function automatic wb_addr_t reg_addr(input reg_sel_t r);
        case (r)
            REG_SEL_DATA:   return wb_addr_t'(`REG_DATA);
            REG_SEL_CMD:    return wb_addr_t'(`REG_CMD);
            REG_SEL_STATUS: return wb_addr_t'(`REG_STATUS);
            default:        return wb_addr_t'(`REG_STATUS + 1);  // first unmapped word
        endcase
    endfunction

    function automatic char_t hex_digit(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[nib];
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_char(input string name, input char_t exp, input char_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic wb_write(input wb_addr_t a, input wb_data_t d, input wb_sel_t s);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        dat_w <= d;
        sel   <= s;
        @(negedge clk);
        while (!ack) @(negedge clk);
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t a, output wb_data_t d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        sel <= 4'hf;
        @(negedge clk);
        while (!ack) @(negedge clk);
        d = dat_r;  // dat_r is valid alongside ack
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic wait_chars(input int n);
        while (rx_q.size() < n) @(negedge clk);
    endtask

    // pops eight characters and compares them with the hex digits of w
    task automatic check_hex_word(input word_t w);
        for (int i = 0; i < 8; i++) begin
            check_char($sformatf("char%0d", i), hex_digit(w[31-4*i -: 4]), rx_q.pop_front());
        end
    endtask

    task automatic print_word(input word_t w);
        wb_data_t st;
        wb_write(reg_addr(REG_SEL_DATA), w, 4'hf);
        wb_write(reg_addr(REG_SEL_CMD), 32'h1, 4'hf);
        wb_read(reg_addr(REG_SEL_STATUS), st);
        check_bit("busy", 1'b1, st[0]);
        wait_chars(8);
        check_hex_word(w);
        wb_read(reg_addr(REG_SEL_STATUS), st);
        check_bit("busy", 1'b0, st[0]);
    endtask

    task automatic close_test(input string name, input int errs_before);
        $display("[%s] finished with %0d errors", name, errors - errs_before);
        if (errors == errs_before) tests_ok++;
        else tests_bad++;
    endtask

    task automatic test_reset();
        wb_data_t st;
        int       e0;
        e0 = errors;
        check_bit("tx", 1'b1, tx);
        wb_read(reg_addr(REG_SEL_STATUS), st);
        check_word("status", 32'h0, st);
        repeat (2 * FRAME_CYC) @(posedge clk);
        if (rx_q.size() != 0) begin
            $display("a character arrived although nothing was printed");
            errors++;
        end
        close_test("reset_state", e0);
    endtask

    task automatic test_regs();
        wb_data_t rd;
        int       e0;
        e0 = errors;
        wb_write(reg_addr(REG_SEL_DATA), 32'h1234_5678, 4'hf);
        wb_read(reg_addr(REG_SEL_DATA), rd);
        check_word("data", 32'h1234_5678, rd);
        wb_write(reg_addr(REG_SEL_DATA), 32'haabb_ccdd, 4'b0101);  // lanes 0 and 2
        wb_read(reg_addr(REG_SEL_DATA), rd);
        check_word("data", 32'h12bb_56dd, rd);
        wb_write(reg_addr(REG_SEL_NONE), 32'hffff_ffff, 4'hf);
        wb_read(reg_addr(REG_SEL_NONE), rd);
        check_word("unmapped", 32'h0, rd);
        wb_read(wb_addr_t'(4'hf), rd);
        check_word("unmapped", 32'h0, rd);
        wb_read(reg_addr(REG_SEL_DATA), rd);
        check_word("data", 32'h12bb_56dd, rd);
        close_test("register_access", e0);
    endtask

    task automatic test_byte();
        wb_data_t st;
        int       e0;
        e0 = errors;
        wb_write(reg_addr(REG_SEL_DATA), 32'hdead_be5a, 4'hf);
        wb_write(reg_addr(REG_SEL_CMD), 32'h0, 4'hf);
        wb_read(reg_addr(REG_SEL_STATUS), st);
        check_bit("busy", 1'b1, st[0]);
        wait_chars(1);
        wb_read(reg_addr(REG_SEL_STATUS), st);
        check_bit("busy", 1'b0, st[0]);
        repeat (FRAME_CYC) @(posedge clk);
        if (rx_q.size() != 1) begin
            $display("byte print sent %0d characters instead of one", rx_q.size());
            errors++;
        end
        check_char("rx_char", 8'h5a, rx_q.pop_front());
        rx_q.delete();
        close_test("byte_print", e0);
    endtask

    task automatic test_word();
        int e0;
        e0 = errors;
        print_word(32'h09af_3c7e);
        close_test("word_print", e0);
    endtask

    task automatic test_backpressure();
        wb_data_t st;
        int       seen;
        int       e0;
        e0 = errors;
        wb_write(reg_addr(REG_SEL_DATA), 32'h0bad_f00d, 4'hf);
        wb_write(reg_addr(REG_SEL_CMD), 32'h1, 4'hf);
        wb_write(reg_addr(REG_SEL_DATA), 32'h7e57_c0de, 4'hf);  // lands mid print
        wb_read(reg_addr(REG_SEL_STATUS), st);
        check_bit("busy", 1'b1, st[0]);
        wb_write(reg_addr(REG_SEL_CMD), 32'h1, 4'hf);            // stalls on busy
        seen = rx_q.size();
        if (seen < 7) begin
            $display("second command accepted after only %0d characters of the first", seen);
            errors++;
        end
        wait_chars(16);
        check_hex_word(32'h0bad_f00d);
        check_hex_word(32'h7e57_c0de);
        close_test("back_pressure", e0);
    endtask

    task automatic test_random();
        int e0;
        e0 = errors;
        for (int n = 0; n < 10; n++) begin
            rng = xorshift(rng);
            print_word(rng);
        end
        close_test("random_words", e0);
    endtask

    initial begin : uart_rx
        char_t c;
        @(negedge rst);
        forever begin
            @(negedge tx);
            repeat (`CLKS_PER_BIT / 2) @(negedge clk);  // middle of the start bit
            if (tx !== 1'b0) begin
                $display("start bit not held low, glitch on the tx line");
                errors++;
            end else begin
                for (int i = 0; i < 8; i++) begin
                    repeat (`CLKS_PER_BIT) @(negedge clk);
                    c[i] = tx;
                end
                repeat (`CLKS_PER_BIT) @(negedge clk);
                if (tx !== 1'b1) begin
                    $display("framing error, stop bit low after character %h", c);
                    errors++;
                end
                rx_q.push_back(c);
            end
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        sel       = '0;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        cycles    = 0;
        rng       = 32'hc63;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_regs();
        test_byte();
        test_word();
        test_backpressure();
        test_random();
        $display("tests ok %0d, tests with errors %0d, total errors %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
common/print_types_pkg.sv
common/wb_types_pkg.sv
console/uart_tx.sv
console/print_unit.sv
source/wb_console_regs.sv
source/console_top.sv
sim/console_checker.sv
sim/console_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the console testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module console_tb \
    -f vlog.f -Mdir obj_dir > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }

./obj_dir/Vconsole_tb > sim.log 2>&1
status=$?
cat sim.log

grep -q "test failed" sim.log && { echo "simulation reported failure"; exit 1; }
[ "$status" -eq 0 ] && grep -q "test passed" sim.log \
    && { echo "simulation ok"; exit 0; } \
    || { echo "simulation ended abnormally"; exit 1; }
